// File: common/mem_msg_pkg.sv
/* Message formats on the requester side and the line-wide memory side
   of the prefetch buffer */
package mem_msg_pkg;

  // ====================
  // Requester side
  // ====================

  // Code 2 is the init write of the wider message family and stays free
  typedef enum logic [2:0] {
    cache_op_read    = 3'd0,
    cache_op_write   = 3'd1,
    cache_op_amo_add = 3'd3,
    cache_op_amo_and = 3'd4,
    cache_op_amo_or  = 3'd5
  } cache_op_t;

  typedef struct packed {
    cache_op_t   op;
    logic [31:0] addr;
    logic [31:0] data;
  } cache_req_t;

  typedef struct packed {
    cache_op_t   op;
    logic [31:0] data;
  } cache_resp_t;

  // ====================
  // Memory side
  // ====================

  typedef enum logic {
    mem_op_read  = 1'b0,
    mem_op_write = 1'b1
  } mem_op_t;

  // Address is always line aligned
  typedef struct packed {
    mem_op_t      op;
    logic [31:0]  addr;
    logic [127:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [127:0] data;
  } mem_resp_t;

endpackage

// File: common/pbuf_pkg.sv
/* Internal types of the prefetch buffer: address split, FSM states and
   the control and status bundles between control and datapath */
package pbuf_pkg;

  localparam int word_bits        = 32;
  localparam int line_bits        = 128;
  localparam int byte_offset_bits = 2;
  localparam int word_offset_bits = 2;
  localparam int offset_bits      = byte_offset_bits + word_offset_bits;

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_evict_req,
    st_evict_wait,
    st_refill_req,
    st_refill_wait,
    st_refill_write,
    st_read,
    st_update,
    st_resp
  } pbuf_state_t;

  // New word source for updates
  typedef enum logic [1:0] {
    amo_sel_data,
    amo_sel_add,
    amo_sel_and,
    amo_sel_or
  } amo_sel_t;

  // ====================
  // Control to datapath
  // ====================

  typedef struct packed {
    logic     req_en;
    logic     tag_ren;
    logic     tag_wen;
    logic     way;
    logic     mark_dirty;
    logic     lru_update;
    logic     data_ren;
    logic     data_wen;
    logic     is_refill;
    logic     line_reg_en;
    amo_sel_t amo_sel;
    logic     mem_addr_sel;
  } pbuf_ctrl_t;

  // Datapath to control
  typedef struct packed {
    logic                  hit;
    logic                  hit_way;
    logic                  victim_dirty;
    logic                  victim_way;
    mem_msg_pkg::cache_op_t op;
  } pbuf_status_t;

endpackage

// File: prefetch_buffer/pbuf_ctrl.sv
/* Prefetch buffer control FSM. Sequences tag check, eviction, refill,
   line read, update and response, and drives the datapath controls */
module pbuf_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cachereq_val,
  input  logic                   memresp_val,
  input  pbuf_pkg::pbuf_status_t status,
  output pbuf_pkg::pbuf_ctrl_t   ctrl,
  output logic                   busy,
  output logic                   cacheresp_val,
  output logic                   memreq_val,
  output mem_msg_pkg::mem_op_t   memreq_op
);
  import pbuf_pkg::*;
  import mem_msg_pkg::*;

  pbuf_state_t state;
  pbuf_state_t state_next;
  logic        way_q;
  logic        is_store;
  amo_sel_t    amo_sel;

  // ====================
  // State register
  // ====================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (cachereq_val) begin
          state_next = st_tag_check;
        end
      end
      st_tag_check: begin
        if (status.hit) begin
          state_next = st_read;
        end else if (status.victim_dirty) begin
          state_next = st_evict_req;
        end else begin
          state_next = st_refill_req;
        end
      end
      st_evict_req:    state_next = st_evict_wait;
      st_evict_wait: begin
        if (memresp_val) begin
          state_next = st_refill_req;
        end
      end
      st_refill_req:   state_next = st_refill_wait;
      st_refill_wait: begin
        if (memresp_val) begin
          state_next = st_refill_write;
        end
      end
      // Refilled line goes on as a hit
      st_refill_write: state_next = st_read;
      st_read:         state_next = is_store ? st_update : st_resp;
      st_update:       state_next = st_resp;
      st_resp:         state_next = st_idle;
      default:         state_next = st_idle;
    endcase
  end

  // Hit way or victim way of the current access
  always_ff @(posedge clk) begin
    if (reset) begin
      way_q <= 1'b0;
    end else if (state == st_tag_check) begin
      way_q <= status.hit ? status.hit_way : status.victim_way;
    end
  end

  // ====================
  // Op decode
  // ====================

  assign is_store = (status.op != cache_op_read);

  always_comb begin
    case (status.op)
      cache_op_amo_add: amo_sel = amo_sel_add;
      cache_op_amo_and: amo_sel = amo_sel_and;
      cache_op_amo_or:  amo_sel = amo_sel_or;
      default:          amo_sel = amo_sel_data;
    endcase
  end

  // Control bundle per state
  always_comb begin
    ctrl         = '0;
    ctrl.way     = (state == st_tag_check) ? status.victim_way : way_q;
    ctrl.amo_sel = amo_sel;
    case (state)
      st_idle: ctrl.req_en = cachereq_val;
      st_tag_check: begin
        ctrl.tag_ren     = 1'b1;
        // victim line is fetched now in case it has to be written back
        ctrl.data_ren    = ~status.hit;
        ctrl.line_reg_en = ~status.hit;
      end
      st_evict_req, st_evict_wait: ctrl.mem_addr_sel = 1'b1;
      st_refill_write: begin
        ctrl.tag_wen    = 1'b1;
        ctrl.data_wen   = 1'b1;
        ctrl.is_refill  = 1'b1;
        ctrl.lru_update = 1'b1;
      end
      st_read: begin
        ctrl.data_ren    = 1'b1;
        ctrl.line_reg_en = 1'b1;
      end
      st_update: begin
        ctrl.data_wen   = 1'b1;
        ctrl.mark_dirty = is_store;
      end
      st_resp: ctrl.lru_update = 1'b1;
      default: ;
    endcase
  end

  assign busy          = (state != st_idle);
  assign cacheresp_val = (state == st_resp);
  assign memreq_val    = (state == st_evict_req) || (state == st_refill_req);
  assign memreq_op     = (state == st_evict_req) ? mem_op_write : mem_op_read;

endmodule

// File: prefetch_buffer/pbuf_tag_ways.sv
/* Two-way tag store with valid, dirty and per-set LRU bits. Compares the
   request tag, picks the victim and forms the memory line address */
module pbuf_tag_ways #(
  parameter int  num_sets = 8,
  localparam int idx_bits = $clog2(num_sets),
  localparam int tag_bits = 32 - idx_bits - pbuf_pkg::offset_bits
) (
  input  logic                 clk,
  input  logic                 reset,
  input  pbuf_pkg::pbuf_ctrl_t ctrl,
  input  logic [tag_bits-1:0]  req_tag,
  input  logic [idx_bits-1:0]  req_index,
  output logic                 hit,
  output logic                 hit_way,
  output logic                 victim_dirty,
  output logic                 victim_way,
  output logic [31:0]          mem_addr
);
  import pbuf_pkg::*;

  logic [tag_bits-1:0]         tags [2][num_sets];
  logic [1:0][num_sets-1:0]    valid;
  logic [1:0][num_sets-1:0]    dirty;
  logic [num_sets-1:0]         lru;
  logic [1:0]                  match;
  logic [tag_bits-1:0]         victim_tag_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (ctrl.tag_wen) begin
        valid[ctrl.way][req_index] <= 1'b1;
        dirty[ctrl.way][req_index] <= 1'b0;
      end
      if (ctrl.mark_dirty) begin
        dirty[ctrl.way][req_index] <= 1'b1;
      end
      // LRU points at the way not just used
      if (ctrl.lru_update) begin
        lru[req_index] <= ~ctrl.way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) begin
      tags[ctrl.way][req_index] <= req_tag;
    end
    if (ctrl.tag_ren) begin
      victim_tag_q <= tags[victim_way][req_index];
    end
  end

  assign match[0] = valid[0][req_index] && (tags[0][req_index] == req_tag);
  assign match[1] = valid[1][req_index] && (tags[1][req_index] == req_tag);
  assign hit      = |match;
  assign hit_way  = match[1];

  // Invalid ways fill first
  always_comb begin
    if (!valid[0][req_index]) begin
      victim_way = 1'b0;
    end else if (!valid[1][req_index]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru[req_index];
    end
  end

  assign victim_dirty = dirty[victim_way][req_index];

  assign mem_addr = ctrl.mem_addr_sel ? {victim_tag_q, req_index, {offset_bits{1'b0}}}
                                      : {req_tag, req_index, {offset_bits{1'b0}}};

endmodule

// File: prefetch_buffer/pbuf_data_store.sv
/* Line data array with byte enables, refill capture and the read line
   register that feeds both the response word and the write-back data */
module pbuf_data_store #(
  parameter int  num_sets = 8,
  localparam int idx_bits = $clog2(num_sets)
) (
  input  logic                                       clk,
  input  logic                                       reset,
  input  pbuf_pkg::pbuf_ctrl_t                       ctrl,
  input  logic [idx_bits-1:0]                        req_index,
  input  logic [pbuf_pkg::word_offset_bits-1:0]      word_offset,
  input  logic [pbuf_pkg::line_bits-1:0]             write_line,
  input  mem_msg_pkg::mem_resp_t                     memresp,
  input  logic                                       memresp_val,
  output logic [pbuf_pkg::line_bits-1:0]             line
);
  import pbuf_pkg::*;

  localparam int line_bytes = line_bits / 8;

  logic [line_bits-1:0]  lines [2 * num_sets];
  logic [idx_bits:0]     addr;
  logic [line_bits-1:0]  refill_line;
  logic [line_bits-1:0]  wdata;
  logic [line_bits-1:0]  rd_line;
  logic [line_bytes-1:0] wben;

  // Lines are laid out as set then way
  assign addr = {req_index, ctrl.way};

  always_ff @(posedge clk) begin
    if (memresp_val) begin
      refill_line <= memresp.data;
    end
  end

  // Whole line on refill, one word on update
  assign wben  = ctrl.is_refill ? {line_bytes{1'b1}}
                                : {{(line_bytes - 4){1'b0}}, 4'hf} << (word_offset * 4);
  assign wdata = ctrl.is_refill ? refill_line : write_line;

  always_ff @(posedge clk) begin
    if (ctrl.data_wen) begin
      for (int b = 0; b < line_bytes; b++) begin
        if (wben[b]) begin
          lines[addr][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  assign rd_line = ctrl.data_ren ? lines[addr] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      line <= '0;
    end else if (ctrl.line_reg_en) begin
      line <= rd_line;
    end
  end

endmodule

// File: prefetch_buffer/pbuf_word_path.sv
/* Request register, address split, word select and the atomic unit that
   builds the replicated write line and the response */
module pbuf_word_path #(
  parameter int  num_sets = 8,
  localparam int idx_bits = $clog2(num_sets),
  localparam int tag_bits = 32 - idx_bits - pbuf_pkg::offset_bits
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  pbuf_pkg::pbuf_ctrl_t                  ctrl,
  input  mem_msg_pkg::cache_req_t               cachereq,
  input  logic [pbuf_pkg::line_bits-1:0]        line,
  output logic [tag_bits-1:0]                   req_tag,
  output logic [idx_bits-1:0]                   req_index,
  output logic [pbuf_pkg::word_offset_bits-1:0] word_offset,
  output mem_msg_pkg::cache_op_t                op,
  output logic [pbuf_pkg::line_bits-1:0]        write_line,
  output mem_msg_pkg::cache_resp_t              cacheresp
);
  import pbuf_pkg::*;
  import mem_msg_pkg::*;

  cache_req_t           req_q;
  logic [word_bits-1:0] old_word;
  logic [word_bits-1:0] new_word;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q <= '0;
    end else if (ctrl.req_en) begin
      req_q <= cachereq;
    end
  end

  // Address fields
  assign req_tag     = req_q.addr[31 -: tag_bits];
  assign req_index   = req_q.addr[offset_bits +: idx_bits];
  assign word_offset = req_q.addr[byte_offset_bits +: word_offset_bits];
  assign op          = req_q.op;

  assign old_word = line[word_offset * word_bits +: word_bits];

  always_comb begin
    case (ctrl.amo_sel)
      amo_sel_add: new_word = req_q.data + old_word;
      amo_sel_and: new_word = req_q.data & old_word;
      amo_sel_or:  new_word = req_q.data | old_word;
      default:     new_word = req_q.data;
    endcase
  end

  // Byte enables in the data store pick the live copy
  assign write_line = {(line_bits / word_bits){new_word}};

  assign cacheresp = '{op: req_q.op, data: old_word};

endmodule

// File: rtl/prefetch_buffer_top.sv
/* Two-way write-back prefetch buffer between a word requester and a
   line-wide memory */
module prefetch_buffer_top #(
  parameter int num_sets = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cachereq_val,
  input  mem_msg_pkg::cache_req_t  cachereq,
  output logic                     busy,
  output logic                     cacheresp_val,
  output mem_msg_pkg::cache_resp_t cacheresp,
  output logic                     memreq_val,
  output mem_msg_pkg::mem_req_t    memreq,
  input  logic                     memresp_val,
  input  mem_msg_pkg::mem_resp_t   memresp
);
  import pbuf_pkg::*;
  import mem_msg_pkg::*;

  localparam int idx_bits = $clog2(num_sets);
  localparam int tag_bits = 32 - idx_bits - offset_bits;

  pbuf_ctrl_t                  ctrl;
  pbuf_status_t                status;
  mem_op_t                     memreq_op;
  cache_op_t                   op;
  logic [tag_bits-1:0]         req_tag;
  logic [idx_bits-1:0]         req_index;
  logic [word_offset_bits-1:0] word_offset;
  logic [line_bits-1:0]        write_line;
  logic [line_bits-1:0]        line;
  logic [31:0]                 mem_addr;
  logic                        hit;
  logic                        hit_way;
  logic                        victim_dirty;
  logic                        victim_way;

  assign status = '{
    hit:          hit,
    hit_way:      hit_way,
    victim_dirty: victim_dirty,
    victim_way:   victim_way,
    op:           op
  };

  // Write-back data and refill requests share the line register
  assign memreq = '{op: memreq_op, addr: mem_addr, data: line};

  pbuf_ctrl u_pbuf_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .memresp_val   (memresp_val),
    .status        (status),
    .ctrl          (ctrl),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .memreq_val    (memreq_val),
    .memreq_op     (memreq_op)
  );

  pbuf_tag_ways #(.num_sets(num_sets)) u_pbuf_tag_ways (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl),
    .req_tag      (req_tag),
    .req_index    (req_index),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_dirty (victim_dirty),
    .victim_way   (victim_way),
    .mem_addr     (mem_addr)
  );

  pbuf_data_store #(.num_sets(num_sets)) u_pbuf_data_store (
    .clk         (clk),
    .reset       (reset),
    .ctrl        (ctrl),
    .req_index   (req_index),
    .word_offset (word_offset),
    .write_line  (write_line),
    .memresp     (memresp),
    .memresp_val (memresp_val),
    .line        (line)
  );

  pbuf_word_path #(.num_sets(num_sets)) u_pbuf_word_path (
    .clk         (clk),
    .reset       (reset),
    .ctrl        (ctrl),
    .cachereq    (cachereq),
    .line        (line),
    .req_tag     (req_tag),
    .req_index   (req_index),
    .word_offset (word_offset),
    .op          (op),
    .write_line  (write_line),
    .cacheresp   (cacheresp)
  );

endmodule

// File: tests/tb_mem_model.sv
/* Line-wide memory model for the prefetch buffer testbench. Answers each
   request after 1 to 5 cycles and counts read and write requests */
module tb_mem_model (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   memreq_val,
  input  mem_msg_pkg::mem_req_t  memreq,
  output logic                   memresp_val,
  output mem_msg_pkg::mem_resp_t memresp,
  output int                     rd_count,
  output int                     wr_count,
  output mem_msg_pkg::mem_req_t  last_wr
);
  timeunit 1ns;
  timeprecision 1ps;
  import mem_msg_pkg::*;

  logic [127:0] lines [logic [31:0]];
  logic [127:0] resp_line;
  logic         pending;
  int           wait_cnt;

  // Untouched word at byte address a holds a xor 5a5a0000
  function automatic logic [127:0] fill_line(logic [31:0] addr);
    logic [127:0] l;
    for (int w = 0; w < 4; w++) begin
      l[w*32 +: 32] = (addr + 32'(w * 4)) ^ 32'h5a5a_0000;
    end
    return l;
  endfunction

  initial begin
    memresp_val = 1'b0;
    memresp     = '0;
  end

  always @(posedge clk) begin
    memresp_val <= 1'b0;
    if (reset) begin
      pending  <= 1'b0;
      wait_cnt <= 0;
      rd_count <= 0;
      wr_count <= 0;
      last_wr  <= '0;
      memresp  <= '0;
    end else if (memreq_val) begin
      pending  <= 1'b1;
      wait_cnt <= $urandom_range(4, 0);
      if (memreq.op == mem_op_write) begin
        lines[memreq.addr] = memreq.data;
        wr_count  <= wr_count + 1;
        last_wr   <= memreq;
        resp_line <= memreq.data;
      end else begin
        rd_count  <= rd_count + 1;
        resp_line <= lines.exists(memreq.addr) ? lines[memreq.addr] : fill_line(memreq.addr);
      end
    end else if (pending) begin
      if (wait_cnt == 0) begin
        memresp_val  <= 1'b1;
        memresp.data <= resp_line;
        pending      <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

// File: tests/tb_prefetch_buffer.sv
/* Testbench for the prefetch buffer. Directed tests checked against a
   reference memory, with a line-wide memory model behind the DUT */
module tb_prefetch_buffer;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_msg_pkg::*;

  localparam int          num_reqs = 220;
  localparam logic [31:0] base     = 32'h0000_1000;

  logic        clk;
  logic        reset;
  logic        cachereq_val;
  cache_req_t  cachereq;
  logic        busy;
  logic        cacheresp_val;
  cache_resp_t cacheresp;
  logic        memreq_val;
  mem_req_t    memreq;
  logic        memresp_val;
  mem_resp_t   memresp;
  mem_req_t    last_wr;
  int          rd_count;
  int          wr_count;
  int          resp_count;
  int          errors;
  int          timeouts;
  logic [31:0] ref_mem [1024];

  prefetch_buffer_top #(.num_sets(8)) u_prefetch_buffer_top (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq      (cachereq),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .cacheresp     (cacheresp),
    .memreq_val    (memreq_val),
    .memreq        (memreq),
    .memresp_val   (memresp_val),
    .memresp       (memresp)
  );

  tb_mem_model u_mem_model (
    .clk         (clk),
    .reset       (reset),
    .memreq_val  (memreq_val),
    .memreq      (memreq),
    .memresp_val (memresp_val),
    .memresp     (memresp),
    .rd_count    (rd_count),
    .wr_count    (wr_count),
    .last_wr     (last_wr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      resp_count <= 0;
    end else if (cacheresp_val) begin
      resp_count <= resp_count + 1;
    end
  end

  // Slowest miss is well under 40 cycles
  initial begin
    #((num_reqs * 40 + 200) * 8);
    $display("watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  // ====================
  // Reference and compare
  // ====================

  // Returns the old word and applies the operation
  function automatic logic [31:0] apply_ref(cache_req_t req);
    int          idx;
    logic [31:0] old;
    idx = int'((req.addr - base) >> 2);
    old = ref_mem[idx];
    case (req.op)
      cache_op_write:   ref_mem[idx] = req.data;
      cache_op_amo_add: ref_mem[idx] = old + req.data;
      cache_op_amo_and: ref_mem[idx] = old & req.data;
      cache_op_amo_or:  ref_mem[idx] = old | req.data;
      default:          ;
    endcase
    return old;
  endfunction

  function automatic logic [127:0] ref_line(logic [31:0] addr);
    logic [127:0] l;
    for (int w = 0; w < 4; w++) begin
      l[w*32 +: 32] = ref_mem[int'((addr - base) >> 2) + w];
    end
    return l;
  endfunction

  task automatic check_resp(input string name, input cache_resp_t exp, input cache_resp_t act);
    if (exp !== act) begin
      $display("error %s: expected op %0d data %h, actual op %0d data %h",
               name, exp.op, exp.data, act.op, act.data);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp !== act) begin
      $display("error %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_memreq(input string name, input mem_req_t exp, input mem_req_t act);
    if (exp !== act) begin
      $display("error %s: expected op %0d addr %h data %h, actual op %0d addr %h data %h",
               name, exp.op, exp.addr, exp.data, act.op, act.addr, act.data);
      errors++;
    end
  endtask

  // ====================
  // Request driving
  // ====================

  // Latency counts cycles after the edge that took the request
  task automatic wait_resp(input string name, output cache_resp_t resp, output int lat);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (cacheresp_val !== 1'b1 && lat < 100);
    resp = cacheresp;
    if (cacheresp_val !== 1'b1) begin
      $display("timeout: no response to %s within 100 cycles", name);
      timeouts++;
    end
  endtask

  task automatic access(input string name, input cache_op_t op, input logic [31:0] addr,
                        input logic [31:0] data, output int lat);
    cache_req_t  req;
    cache_resp_t exp;
    cache_resp_t resp;
    req = '{op: op, addr: addr, data: data};
    exp = '{op: op, data: apply_ref(req)};
    @(posedge clk);
    cachereq_val <= 1'b1;
    cachereq     <= req;
    @(posedge clk);
    cachereq_val <= 1'b0;
    wait_resp(name, resp, lat);
    check_resp(name, exp, resp);
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic reset_and_cold_miss();
    int lat;
    int rd0;
    int wr0;
    @(negedge clk);
    if (busy !== 1'b0 || cacheresp_val !== 1'b0 || memreq_val !== 1'b0) begin
      $display("outputs not idle after reset: busy %b cacheresp_val %b memreq_val %b",
               busy, cacheresp_val, memreq_val);
      errors++;
    end
    rd0 = rd_count;
    wr0 = wr_count;
    access("cold miss", cache_op_read, base, 32'h0, lat);
    check_count("cold miss reads", rd0 + 1, rd_count);
    check_count("cold miss writes", wr0, wr_count);
    access("same line read", cache_op_read, base + 4, 32'h0, lat);
    check_count("same line latency", 3, lat);
    check_count("same line memreqs", rd0 + wr0 + 1, rd_count + wr_count);
  endtask

  task automatic write_hit();
    int lat;
    int n0;
    n0 = rd_count + wr_count;
    access("write hit", cache_op_write, base + 8, 32'hdead_beef, lat);
    check_count("write hit latency", 4, lat);
    access("write read back", cache_op_read, base + 8, 32'h0, lat);
    check_count("write hit memreqs", n0, rd_count + wr_count);
  endtask

  task automatic atomics();
    int lat;
    access("amo_add", cache_op_amo_add, base + 12, 32'h0000_1234, lat);
    check_count("amo_add latency", 4, lat);
    access("amo_add read", cache_op_read, base + 12, 32'h0, lat);
    access("amo_and", cache_op_amo_and, base + 12, 32'hf0f0_ff00, lat);
    access("amo_and read", cache_op_read, base + 12, 32'h0, lat);
    access("amo_or", cache_op_amo_or, base + 12, 32'h0101_0001, lat);
    access("amo_or read", cache_op_read, base + 12, 32'h0, lat);
  endtask

  // Lines a, b and c all map to set 1
  task automatic lru_write_back();
    int       lat;
    int       rd0;
    int       wr0;
    mem_req_t exp_wb;
    access("lru read a", cache_op_read, base + 32'h010, 32'h0, lat);
    access("lru write b", cache_op_write, base + 32'h094, 32'hcafe_f00d, lat);
    access("lru read a again", cache_op_read, base + 32'h010, 32'h0, lat);
    rd0    = rd_count;
    wr0    = wr_count;
    exp_wb = '{op: mem_op_write, addr: base + 32'h090, data: ref_line(base + 32'h090)};
    access("lru read c", cache_op_read, base + 32'h110, 32'h0, lat);
    check_count("evict reads", rd0 + 1, rd_count);
    check_count("evict writes", wr0 + 1, wr_count);
    check_memreq("write back of b", exp_wb, last_wr);
    rd0 = rd_count;
    access("lru read a after c", cache_op_read, base + 32'h010, 32'h0, lat);
    check_count("a still resident", rd0, rd_count);
    access("lru refill b", cache_op_read, base + 32'h094, 32'h0, lat);
    check_count("b refill reads", rd0 + 1, rd_count);
    check_count("b refill writes", wr0 + 1, wr_count);
  endtask

  task automatic drop_while_busy();
    int          lat;
    int          n0;
    int          mem0;
    cache_req_t  req;
    cache_resp_t exp;
    cache_resp_t resp;
    @(negedge clk);
    n0   = resp_count;
    mem0 = rd_count + wr_count;
    req  = '{op: cache_op_read, addr: base + 8, data: 32'h0};
    exp  = '{op: cache_op_read, data: apply_ref(req)};
    @(posedge clk);
    cachereq_val <= 1'b1;
    cachereq     <= req;
    @(posedge clk);
    // Second strobe aims at a line that is not resident
    cachereq     <= '{op: cache_op_write, addr: base + 32'h208, data: 32'h1111_2222};
    @(negedge clk);
    if (busy !== 1'b1) begin
      $display("busy was not high during the second strobe");
      errors++;
    end
    @(posedge clk);
    cachereq_val <= 1'b0;
    wait_resp("busy read", resp, lat);
    check_resp("busy read", exp, resp);
    repeat (20) @(negedge clk);
    check_count("responses while busy", n0 + 1, resp_count);
    check_count("memreqs while busy", mem0, rd_count + wr_count);
    access("dropped write absent", cache_op_read, base + 32'h208, 32'h0, lat);
  endtask

  task automatic random_mix();
    int        lat;
    int        k;
    cache_op_t op;
    for (int i = 0; i < 200; i++) begin
      k = $urandom_range(63, 0);
      case ($urandom_range(4, 0))
        0:       op = cache_op_read;
        1:       op = cache_op_write;
        2:       op = cache_op_amo_add;
        3:       op = cache_op_amo_and;
        default: op = cache_op_amo_or;
      endcase
      access($sformatf("random %0d", i), op, base + 32'(k * 36), $urandom(), lat);
    end
  endtask

  initial begin
    void'($urandom(32'hc26f_09f2));
    reset        = 1'b1;
    cachereq_val = 1'b0;
    cachereq     = '0;
    errors       = 0;
    timeouts     = 0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = (base + 32'(i * 4)) ^ 32'h5a5a_0000;
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    reset_and_cold_miss();
    write_hit();
    atomics();
    lru_write_back();
    drop_while_busy();
    random_mix();
    @(negedge clk);
    $display("Error count: %0d wrong values, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tb.f
common/mem_msg_pkg.sv
common/pbuf_pkg.sv
prefetch_buffer/pbuf_ctrl.sv
prefetch_buffer/pbuf_tag_ways.sv
prefetch_buffer/pbuf_data_store.sv
prefetch_buffer/pbuf_word_path.sv
rtl/prefetch_buffer_top.sv
tests/tb_mem_model.sv
tests/tb_prefetch_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the prefetch buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_prefetch_buffer \
  -f tb.f --Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vsim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$log"; then
  echo "Simulation reported failures, see $log"
  exit 1
fi
exit 0
